// File: verilog/frog_pkg.sv
`default_nettype none

package frog_pkg;

    typedef logic [9:0] coord_t;   // Screen x or y
    typedef logic [23:0] color_t;  // 8 bits each of R, G, B

    localparam int NUM_CARS = 10;
    localparam int NUM_LANES = 5;

    // Screen and sprite geometry
    localparam coord_t SCREEN_W = 10'd640;
    localparam coord_t SCREEN_H = 10'd480;
    localparam coord_t CAR_W = 10'd40;
    localparam coord_t CAR_H = 10'd20;
    localparam coord_t FROG_SIZE = 10'd15;
    localparam coord_t CAR_STEP = 10'd5;   // Pixels per traffic tick

    localparam coord_t FROG_START_X = 10'd320;
    localparam coord_t FROG_START_Y = 10'd451;
    localparam coord_t FROG_MIN_X = 10'd20;
    localparam coord_t FROG_MIN_Y = 10'd5;
    localparam coord_t FROG_MAX_X = 10'd620;
    localparam coord_t FROG_MAX_Y = 10'd460;
    localparam coord_t WIN_Y = 10'd30;     // Top band reached at or above this

    // Lane tops, bottom lane first; car i drives in lane i/2
    localparam coord_t LANE_Y [NUM_LANES] = '{10'd403, 10'd315, 10'd230, 10'd141, 10'd54};

    localparam coord_t CAR_START_X [NUM_CARS] = '{
        10'd0, 10'd300, 10'd20, 10'd340, 10'd10,
        10'd350, 10'd0, 10'd240, 10'd0, 10'd322
    };

    // Background bands, each road spans (top, bot]
    localparam coord_t SKY_BOT = 10'd35;
    localparam coord_t ROAD_TOP [NUM_LANES] = '{10'd35, 10'd123, 10'd211, 10'd299, 10'd387};
    localparam coord_t ROAD_BOT [NUM_LANES] = '{10'd79, 10'd167, 10'd255, 10'd343, 10'd431};

    localparam color_t SKY = 24'h00FFFF;
    localparam color_t ROAD = 24'h000000;
    localparam color_t MEDIAN = 24'hAAAAAA;
    localparam color_t FROG_COLOR = 24'h014820;
    localparam color_t WIN_COLOR = 24'h00FF00;
    localparam color_t LOSE_COLOR = 24'hFF0000;

    localparam color_t PINK = 24'hFFC0CB;
    localparam color_t BLUE = 24'h0000FF;
    localparam color_t RED = 24'hFF0000;
    localparam color_t ORANGE = 24'hFFA500;
    localparam color_t PURPLE = 24'h800080;
    localparam color_t YELLOW = 24'hFFFF00;

    localparam color_t CAR_COLOR [NUM_CARS] = '{
        PINK, BLUE, RED, ORANGE, ORANGE,
        PURPLE, PURPLE, ORANGE, PINK, YELLOW
    };

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } frog_keys_t;

    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
    } pix_req_t;

    typedef struct packed {
        logic   valid;
        color_t color;
    } pix_resp_t;

    typedef coord_t [NUM_CARS-1:0] car_pos_t;

endpackage

`default_nettype wire

// File: verilog/car_traffic.sv
`timescale 1ns/1ps
`default_nettype none

module car_traffic #(
    parameter int CAR_PERIOD = 1500000
) (
    input  wire logic         clk,
    input  wire logic         rst,
    output frog_pkg::car_pos_t car_x
);

    localparam int TW = $clog2(CAR_PERIOD + 1);

    logic [TW-1:0] timer;   // Cycles since the last traffic tick
    logic          tick;

    assign tick = (timer == TW'(CAR_PERIOD));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            timer <= '0;
        end else if (tick) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // All cars move together, right only
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
                car_x[i] <= frog_pkg::CAR_START_X[i];
            end
        end else if (tick) begin
            for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
                if (car_x[i] >= frog_pkg::SCREEN_W) begin
                    car_x[i] <= '0;   // Off the right edge, back to the left
                end else begin
                    car_x[i] <= car_x[i] + frog_pkg::CAR_STEP;
                end
            end
        end
    end

    // Overshoot past the edge is at most one step
    for (genvar g = 0; g < frog_pkg::NUM_CARS; g++) begin : g_chk
        car_in_range: assert property (@(posedge clk) disable iff (!rst)
            car_x[g] <= frog_pkg::SCREEN_W + 10'd4);
    end

endmodule

`default_nettype wire

// File: verilog/frog_control.sv
`timescale 1ns/1ps
`default_nettype none

module frog_control #(
    parameter int FROG_PERIOD = 800000
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  frog_pkg::frog_keys_t    keys,
    output frog_pkg::coord_t        frog_x,
    output frog_pkg::coord_t        frog_y,
    output logic                    win
);

    localparam int TW = $clog2(FROG_PERIOD + 1);

    logic [TW-1:0] timer;

    // Frog timer stalls once the game is won, freezing the frog
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            timer <= '0;
            frog_x <= frog_pkg::FROG_START_X;
            frog_y <= frog_pkg::FROG_START_Y;
        end else if (!win) begin
            if (timer == TW'(FROG_PERIOD)) begin
                timer <= '0;
                // Opposite keys together: right and down take precedence
                if (keys.left && frog_x > frog_pkg::FROG_MIN_X) begin
                    frog_x <= frog_x - 1'b1;
                end
                if (keys.right && frog_x < frog_pkg::FROG_MAX_X) begin
                    frog_x <= frog_x + 1'b1;
                end
                if (keys.up && frog_y > frog_pkg::FROG_MIN_Y) begin
                    frog_y <= frog_y - 1'b1;
                end
                if (keys.down && frog_y < frog_pkg::FROG_MAX_Y) begin
                    frog_y <= frog_y + 1'b1;
                end
            end else begin
                timer <= timer + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            win <= 1'b0;
        end else begin
            win <= (frog_y <= frog_pkg::WIN_Y);   // Top band reached
        end
    end

    frog_in_bounds: assert property (@(posedge clk) disable iff (!rst)
        frog_x >= frog_pkg::FROG_MIN_X && frog_x <= frog_pkg::FROG_MAX_X &&
        frog_y >= frog_pkg::FROG_MIN_Y && frog_y <= frog_pkg::FROG_MAX_Y);

endmodule

`default_nettype wire

// File: verilog/collision_detect.sv
`timescale 1ns/1ps
`default_nettype none

module collision_detect (
    input  wire logic         clk,
    input  wire logic         rst,
    input  frog_pkg::car_pos_t car_x,
    input  frog_pkg::coord_t   frog_x,
    input  frog_pkg::coord_t   frog_y,
    output logic              game_over
);

    logic hit;

    // Frog's top-left corner against each car box
    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
            if (frog_x >= car_x[i] && frog_x < car_x[i] + frog_pkg::CAR_W &&
                frog_y + frog_pkg::FROG_SIZE >= frog_pkg::LANE_Y[i/2] &&
                frog_y < frog_pkg::LANE_Y[i/2] + frog_pkg::CAR_H) begin
                hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            game_over <= 1'b0;
        end else if (hit) begin
            game_over <= 1'b1;   // Held until reset
        end
    end

    game_over_sticky: assert property (@(posedge clk) disable iff (!rst)
        game_over |=> game_over);

endmodule

`default_nettype wire

// File: verilog/pixel_painter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_painter (
    input  wire logic          clk,
    input  wire logic          rst,
    input  frog_pkg::pix_req_t  pix_req,
    input  frog_pkg::car_pos_t  car_x,
    input  frog_pkg::coord_t    frog_x,
    input  frog_pkg::coord_t    frog_y,
    input  wire logic          win,
    input  wire logic          game_over,
    output frog_pkg::pix_resp_t pix_resp
);

    localparam int IDX_W = $clog2(frog_pkg::NUM_CARS);

    // Background classes
    localparam logic [1:0] BG_SKY = 2'd0;
    localparam logic [1:0] BG_ROAD = 2'd1;
    localparam logic [1:0] BG_MEDIAN = 2'd2;

    logic [1:0]       bg;
    logic             frog_hit;
    logic             car_hit;
    logic [IDX_W-1:0] car_idx;

    logic             s1_valid;
    logic [1:0]       s1_bg;
    logic             s1_frog_hit;
    logic             s1_car_hit;
    logic [IDX_W-1:0] s1_car_idx;
    logic             s1_win;
    logic             s1_game_over;

    logic                 resp_valid;
    frog_pkg::color_t     resp_color;

    always_comb begin
        bg = BG_MEDIAN;
        if (pix_req.y <= frog_pkg::SKY_BOT) begin
            bg = BG_SKY;
        end
        for (int b = 0; b < frog_pkg::NUM_LANES; b++) begin
            if (pix_req.y > frog_pkg::ROAD_TOP[b] && pix_req.y <= frog_pkg::ROAD_BOT[b]) begin
                bg = BG_ROAD;
            end
        end
    end

    assign frog_hit = pix_req.x >= frog_x && pix_req.x < frog_x + frog_pkg::FROG_SIZE &&
                      pix_req.y >= frog_y && pix_req.y < frog_y + frog_pkg::FROG_SIZE;

    // Later cars are drawn on top
    always_comb begin
        car_hit = 1'b0;
        car_idx = '0;
        for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
            if (pix_req.x >= car_x[i] && pix_req.x < car_x[i] + frog_pkg::CAR_W &&
                pix_req.y >= frog_pkg::LANE_Y[i/2] &&
                pix_req.y < frog_pkg::LANE_Y[i/2] + frog_pkg::CAR_H) begin
                car_hit = 1'b1;
                car_idx = IDX_W'(i);
            end
        end
    end

    // Stage 1
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pix_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_bg <= bg;
        s1_frog_hit <= frog_hit;
        s1_car_hit <= car_hit;
        s1_car_idx <= car_idx;
        s1_win <= win;
        s1_game_over <= game_over;
    end

    // Stage 2, end screens override the scene
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_game_over) begin
            resp_color <= frog_pkg::LOSE_COLOR;
        end else if (s1_win) begin
            resp_color <= frog_pkg::WIN_COLOR;
        end else if (s1_frog_hit) begin
            resp_color <= frog_pkg::FROG_COLOR;
        end else if (s1_car_hit) begin
            resp_color <= frog_pkg::CAR_COLOR[s1_car_idx];
        end else if (s1_bg == BG_SKY) begin
            resp_color <= frog_pkg::SKY;
        end else if (s1_bg == BG_ROAD) begin
            resp_color <= frog_pkg::ROAD;
        end else begin
            resp_color <= frog_pkg::MEDIAN;
        end
    end

    assign pix_resp.valid = resp_valid;
    assign pix_resp.color = resp_color;

endmodule

`default_nettype wire

// File: verilog/frog_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module frog_game_top #(
    parameter int CAR_PERIOD = 1500000,   // Cycles per traffic tick, minus one
    parameter int FROG_PERIOD = 800000    // Cycles per frog tick, minus one
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  frog_pkg::frog_keys_t keys,
    input  frog_pkg::pix_req_t  pix_req,
    output frog_pkg::pix_resp_t pix_resp,
    output logic               win,
    output logic               game_over
);

    frog_pkg::car_pos_t car_x;
    frog_pkg::coord_t   frog_x;
    frog_pkg::coord_t   frog_y;

    car_traffic #(.CAR_PERIOD(CAR_PERIOD)) traffic_i (
        .clk   (clk),
        .rst   (rst),
        .car_x (car_x)
    );

    frog_control #(.FROG_PERIOD(FROG_PERIOD)) frog_i (
        .clk    (clk),
        .rst    (rst),
        .keys   (keys),
        .frog_x (frog_x),
        .frog_y (frog_y),
        .win    (win)
    );

    collision_detect collide_i (
        .clk       (clk),
        .rst       (rst),
        .car_x     (car_x),
        .frog_x    (frog_x),
        .frog_y    (frog_y),
        .game_over (game_over)
    );

    pixel_painter painter_i (
        .clk       (clk),
        .rst       (rst),
        .pix_req   (pix_req),
        .car_x     (car_x),
        .frog_x    (frog_x),
        .frog_y    (frog_y),
        .win       (win),
        .game_over (game_over),
        .pix_resp  (pix_resp)
    );

endmodule

`default_nettype wire

// File: verif/frog_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frog_game_tb;

    localparam int CAR_PERIOD = 199;
    localparam int FROG_PERIOD = 3;
    localparam int FT = FROG_PERIOD + 1;   // Cycles per frog tick
    // Rough lengths of the five tests in cycles
    localparam int TEST_CYCLES = 330 + 600 + 345 * FT + 200 + 750 * FT;
    localparam int TIMEOUT = 2 * TEST_CYCLES;

    logic                 clk;
    logic                 rst;
    frog_pkg::frog_keys_t keys;
    frog_pkg::pix_req_t   pix_req;
    frog_pkg::pix_resp_t  pix_resp;
    logic                 win;
    logic                 game_over;

    // Reference model state updated on every rising edge
    int          m_car [frog_pkg::NUM_CARS];
    int          m_ctimer;
    int          m_ftimer;
    int          m_fx;
    int          m_fy;
    bit          m_win;
    bit          m_go;
    logic [24:0] exp_q [$];   // {valid, colour} per request cycle

    int          errors;
    int          checks;
    int          tests_failed;
    int          cycle_count;
    int unsigned lcg_state;

    frog_game_top #(.CAR_PERIOD(CAR_PERIOD), .FROG_PERIOD(FROG_PERIOD)) dut_i (
        .clk(clk), .rst(rst), .keys(keys), .pix_req(pix_req),
        .pix_resp(pix_resp), .win(win), .game_over(game_over)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state >> 16);
    endfunction

    // Frog top-left corner inside any car box
    function automatic bit model_overlap();
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
            if (m_fx >= m_car[i] && m_fx < m_car[i] + 40 &&
                m_fy + 15 >= frog_pkg::LANE_Y[i/2] && m_fy < frog_pkg::LANE_Y[i/2] + 20) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Lowest priority first so later rules override
    function automatic logic [23:0] expected_color(int px, int py);
        logic [23:0] c;
        c = frog_pkg::MEDIAN;
        if (py <= 35) begin
            c = frog_pkg::SKY;
        end
        for (int b = 0; b < frog_pkg::NUM_LANES; b++) begin
            if (py > frog_pkg::ROAD_TOP[b] && py <= frog_pkg::ROAD_BOT[b]) begin
                c = frog_pkg::ROAD;
            end
        end
        for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
            if (px >= m_car[i] && px < m_car[i] + 40 &&
                py >= frog_pkg::LANE_Y[i/2] && py < frog_pkg::LANE_Y[i/2] + 20) begin
                c = frog_pkg::CAR_COLOR[i];
            end
        end
        if (px >= m_fx && px < m_fx + 15 && py >= m_fy && py < m_fy + 15) begin
            c = frog_pkg::FROG_COLOR;
        end
        if (m_win) begin
            c = frog_pkg::WIN_COLOR;
        end
        if (m_go) begin
            c = frog_pkg::LOSE_COLOR;
        end
        return c;
    endfunction

    // Column closest to the frog start that no car reaches within the horizon
    function automatic int find_safe_x(int horizon);
        int  reach;
        int  x;
        bit  clear;
        reach = (horizon / (CAR_PERIOD + 1) + 1) * 5;
        for (int d = 0; d < 300; d++) begin
            for (int s = -1; s <= 1; s += 2) begin
                x = 320 + s * d;
                clear = (x >= 20 && x <= 620);
                for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
                    if (x >= frog_pkg::CAR_START_X[i] &&
                        x < frog_pkg::CAR_START_X[i] + 40 + reach) begin
                        clear = 1'b0;
                    end
                end
                if (clear) begin
                    return x;
                end
            end
        end
        return 320;
    endfunction

    always @(posedge clk or negedge rst) begin
        bit hit;
        bit next_win;
        int nx;
        int ny;
        if (!rst) begin
            for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
                m_car[i] = frog_pkg::CAR_START_X[i];
            end
            m_ctimer = 0;
            m_ftimer = 0;
            m_fx = 320;
            m_fy = 451;
            m_win = 1'b0;
            m_go = 1'b0;
            exp_q.delete();
        end else begin
            exp_q.push_back({pix_req.valid, expected_color(pix_req.x, pix_req.y)});
            hit = model_overlap();
            next_win = (m_fy <= 30);
            nx = m_fx;
            ny = m_fy;
            if (!m_win && m_ftimer == FROG_PERIOD) begin
                m_ftimer = 0;
                if (keys.left && m_fx > 20) nx = m_fx - 1;
                if (keys.right && m_fx < 620) nx = m_fx + 1;
                if (keys.up && m_fy > 5) ny = m_fy - 1;
                if (keys.down && m_fy < 460) ny = m_fy + 1;
            end else if (!m_win) begin
                m_ftimer++;
            end
            if (m_ctimer == CAR_PERIOD) begin
                m_ctimer = 0;
                for (int i = 0; i < frog_pkg::NUM_CARS; i++) begin
                    m_car[i] = (m_car[i] >= 640) ? 0 : m_car[i] + 5;   // Wrap past the edge
                end
            end else begin
                m_ctimer++;
            end
            m_fx = nx;
            m_fy = ny;
            m_win = next_win;
            m_go = m_go | hit;
        end
    end

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("MISMATCH at %0t: %s got %0h, expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic check_condition(bit cond, string what);
        checks++;
        assert (cond) else begin
            $display("Check failed at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        logic [24:0] e;
        if (rst) begin
            checks += 2;
            assert (win == m_win) else report_mismatch("win", win, m_win);
            assert (game_over == m_go) else report_mismatch("game_over", game_over, m_go);
            if (exp_q.size() == 2) begin
                e = exp_q.pop_front();
                checks++;
                assert (pix_resp.valid == e[24])
                    else report_mismatch("pix_resp.valid", pix_resp.valid, e[24]);
                if (e[24]) begin
                    assert (pix_resp.color == e[23:0])
                        else report_mismatch("pix_resp.color", pix_resp.color, e[23:0]);
                end
            end
        end
    end

    task automatic drive(frog_pkg::frog_keys_t k, bit v, int x, int y);
        @(posedge clk);
        #2;
        keys = k;
        pix_req.valid = v;
        pix_req.x = frog_pkg::coord_t'(x);
        pix_req.y = frog_pkg::coord_t'(y);
    endtask

    task automatic random_probe(frog_pkg::frog_keys_t k);
        int x;
        int y;
        x = next_rand() % 640;
        y = next_rand() % 480;
        drive(k, 1'b1, x, y);
    endtask

    // Probes around the frog square corners
    task automatic frog_probe(frog_pkg::frog_keys_t k, int n);
        int px;
        int py;
        for (int c = 0; c < n; c++) begin
            px = m_fx + ((c % 4 == 1) ? 14 : (c % 4 == 2) ? 15 : (c % 4 == 3) ? -1 : 0);
            py = m_fy + ((c % 2 == 1) ? 14 : 0);
            drive(k, 1'b1, px, py);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst = 1'b0;
        keys = '0;
        pix_req = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b1;
    endtask

    task automatic finish_test(string name, int err_before);
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Test failed");
        $finish;
    end

    initial begin
        frog_pkg::frog_keys_t k;
        int err0;
        int i;
        int ox;
        int safe_x;
        int hold_x;
        int hold_y;
        lcg_state = 92811;
        errors = 0;
        checks = 0;
        tests_failed = 0;
        rst = 1'b0;
        keys = '0;
        pix_req = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b1;

        err0 = errors;
        drive('0, 1'b1, 100, 10);
        for (int b = 0; b < frog_pkg::NUM_LANES; b++) begin
            drive('0, 1'b1, 500, frog_pkg::ROAD_TOP[b]);
            drive('0, 1'b1, 500, frog_pkg::ROAD_TOP[b] + 1);
            drive('0, 1'b1, 500, frog_pkg::ROAD_BOT[b]);
            drive('0, 1'b1, 500, frog_pkg::ROAD_BOT[b] + 1);
        end
        frog_probe('0, 8);
        for (int c = 0; c < frog_pkg::NUM_CARS; c++) begin
            drive('0, 1'b1, frog_pkg::CAR_START_X[c], frog_pkg::LANE_Y[c/2]);
            drive('0, 1'b1, frog_pkg::CAR_START_X[c] + 39, frog_pkg::LANE_Y[c/2] + 19);
        end
        repeat (300) random_probe('0);
        finish_test("test 1 reset scene", err0);

        err0 = errors;
        for (int c = 0; c < 600; c++) begin
            if (c % 2 == 0) begin
                random_probe('0);
            end else begin
                i = (c / 2) % frog_pkg::NUM_CARS;
                ox = (c % 8 == 1) ? -1 : (c % 8 == 3) ? 0 : (c % 8 == 5) ? 39 : 40;
                drive('0, 1'b1, m_car[i] + ox, frog_pkg::LANE_Y[i/2] + (c % 21));
            end
        end
        finish_test("test 2 traffic", err0);

        err0 = errors;
        k = '0;
        k.left = 1'b1;
        frog_probe(k, 310 * FT);
        check_condition(dut_i.frog_x == 20, "frog did not stop at the left limit");
        k = '0;
        k.right = 1'b1;
        frog_probe(k, 20 * FT);
        k = '0;
        k.down = 1'b1;
        frog_probe(k, 15 * FT);   // Only 9 steps fit below
        check_condition(!game_over, "game_over set although the frog path avoids the cars");
        finish_test("test 3 frog steps and limits", err0);

        err0 = errors;
        apply_reset();
        k = '0;
        k.up = 1'b1;
        while (!model_overlap()) begin
            frog_probe(k, 1);
        end
        check_condition(!game_over, "game_over set before the frog touched a car");
        frog_probe('0, 1);
        check_condition(game_over, "game_over did not rise one cycle after the overlap");
        repeat (60) random_probe('0);
        finish_test("test 4 collision", err0);

        err0 = errors;
        apply_reset();
        safe_x = find_safe_x(750 * FT);
        k = '0;
        if (safe_x < m_fx) k.left = 1'b1;
        else k.right = 1'b1;
        while (m_fx != safe_x) begin
            frog_probe(k, 1);
        end
        k = '0;
        k.up = 1'b1;
        while (m_fy > 30) begin
            frog_probe(k, 1);
        end
        check_condition(!win, "win rose before the frog reached y 30");
        frog_probe(k, 1);
        check_condition(win, "win did not rise one cycle after the frog reached y 30");
        check_condition(!game_over, "frog was hit on the way to the top");
        hold_x = m_fx;
        hold_y = m_fy;
        k = '0;
        k.down = 1'b1;
        k.right = 1'b1;
        repeat (50) random_probe(k);
        frog_probe(k, 40);
        check_condition(dut_i.frog_x == hold_x && dut_i.frog_y == hold_y,
                        "frog moved after the win");
        finish_test("test 5 win", err0);

        $display("Tests run: 5, failed: %0d, checks: %0d, errors: %0d",
                 tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/frog_pkg.sv
verilog/car_traffic.sv
verilog/frog_control.sv
verilog/collision_detect.sv
verilog/pixel_painter.sv
verilog/frog_game_top.sv
verif/frog_game_tb.sv

// File: Makefile
SRCS := $(wildcard verilog/*.sv verif/*.sv)

obj_dir/frog_sim: sim.f $(SRCS)
	verilator --binary --assert -Wno-fatal -f sim.f --top-module frog_game_tb -o frog_sim

run: obj_dir/frog_sim
	@out="$$(./obj_dir/frog_sim)"; echo "$$out"; echo "$$out" | grep -q '^Test passed$$'

clean:
	rm -rf obj_dir

.PHONY: run clean
